// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = vector_coprocessor_tb
FILELIST  = all.f
OBJ_DIR   = obj_dir
PASS_MSG  = NO ERRORS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== all.f ====
design/vec_pkg.sv
design/command_decoder.sv
design/vector_bank.sv
design/vector_engine.sv
design/vector_coprocessor.sv
verification/vector_coprocessor_tb.sv

// ==== design/command_decoder.sv ====
`timescale 1ns/100ps

module command_decoder (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        rx_valid,  // One-cycle byte strobe
	input  logic [vec_pkg::ELEM_W-1:0]  rx_data,
	input  logic                        op_done,   // Engine finished the command
	output logic                        cmd_valid, // Level, held until op_done
	output vec_pkg::cmd_t               cmd,
	output logic                        wr_en,     // Write strobe toward the banks
	output vec_pkg::mem_wr_t            wr
);
	import vec_pkg::*;

	typedef enum logic [1:0] {
		WAIT,    // Looking for a command byte
		DECODE,  // Engine command in flight
		LOAD     // Streaming write data into a bank
	} state_t;

	state_t state, next_state;

	op_t               rx_op;     // Opcode field of the current byte
	logic              rx_bank;   // Bank field of the current byte
	logic              wr_bank;   // Bank latched for the load
	logic [ADDR_W-1:0] load_cnt;  // Next element to be written
	cmd_t              cmd_q;

	// Split the byte into its fields
	assign rx_op   = op_t'(rx_data[OP_W-1:0]);
	assign rx_bank = rx_data[BANK_BIT];

	always_ff @(posedge clk) begin
		if (reset)
			state <= WAIT;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state;  // Hold by default
		case (state)
			WAIT: begin
				if (rx_valid) begin
					if (rx_op == OP_WRITE)
						next_state = LOAD;
					else if (rx_op != OP_NONE)
						next_state = DECODE;  // Any engine opcode
				end
			end
			DECODE: begin
				if (op_done)
					next_state = WAIT;  // cmd_valid drops next cycle
			end
			LOAD: begin
				if (rx_valid && load_cnt == LAST_ADDR)
					next_state = WAIT;  // Last data byte taken
			end
			default: next_state = WAIT;
		endcase
	end

	// Element counter for the load
	always_ff @(posedge clk) begin
		if (reset)
			load_cnt <= '0;
		else if (state != LOAD)
			load_cnt <= '0;
		else if (rx_valid)
			load_cnt <= load_cnt + 1'b1;  // Wraps to 0 after the last one
	end

	// Latch the load bank or the engine command
	always_ff @(posedge clk) begin
		if (state == WAIT && rx_valid) begin
			if (rx_op == OP_WRITE)
				wr_bank <= rx_bank;
			else if (rx_op != OP_NONE) begin
				cmd_q.bank <= rx_bank;
				cmd_q.op   <= rx_op;
			end
		end
	end

	assign cmd_valid = (state == DECODE);
	assign cmd       = cmd_q;

	// Data bytes go straight through in their strobe cycle
	assign wr_en   = (state == LOAD) && rx_valid;
	assign wr.bank = wr_bank;
	assign wr.addr = load_cnt;
	assign wr.data = rx_data;

	// Only engine opcodes reach the engine
	a_cmd_op_legal: assert property (@(posedge clk) disable iff (reset)
		cmd_valid |-> !(cmd.op inside {OP_NONE, OP_WRITE}))
		else $error("command_decoder: cmd_valid with non-engine opcode %0d", cmd.op);

	// A load stays in LOAD until its last element, then falls back to WAIT
	a_wr_in_load: assert property (@(posedge clk) disable iff (reset)
		wr_en |=> state == (($past(wr.addr) == LAST_ADDR) ? WAIT : LOAD))
		else $error("command_decoder: load did not end on its last element");

endmodule

// ==== design/vec_pkg.sv ====
package vec_pkg;

	// Vector geometry
	localparam int VEC_LEN = 8;   // Elements per bank
	localparam int ELEM_W  = 8;   // Unsigned byte elements
	localparam int ADDR_W  = 3;   // Element index width
	localparam int RES_W   = 24;  // Fits eight 255*255 products

	// Index of the final element
	localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(VEC_LEN - 1);

	// Command byte layout
	localparam int BANK_BIT = ELEM_W - 1;  // Bit 7 picks the bank
	localparam int OP_W     = 3;           // Opcode in bits 2 to 0

	// Opcodes as carried in the command byte
	typedef enum logic [OP_W-1:0] {
		OP_NONE  = 3'd0,  // Ignored
		OP_WRITE = 3'd1,  // Load VEC_LEN bytes into a bank
		OP_READ  = 3'd2,  // Dump one bank
		OP_SUM   = 3'd3,  // A + B per element
		OP_AVG   = 3'd4,  // (A + B) / 2 rounded down
		OP_EUC   = 3'd5,  // Sum of squared differences
		OP_MAN   = 3'd6,  // Sum of absolute differences
		OP_DOT   = 3'd7   // Sum of products
	} op_t;

	// Command held for the engine
	typedef struct packed {
		logic bank;  // 0 selects A, 1 selects B
		op_t  op;
	} cmd_t;

	// One memory write
	typedef struct packed {
		logic              bank;
		logic [ADDR_W-1:0] addr;
		logic [ELEM_W-1:0] data;
	} mem_wr_t;

	// Both operands at one address
	typedef struct packed {
		logic [ELEM_W-1:0] a;
		logic [ELEM_W-1:0] b;
	} elem_pair_t;

endpackage

// ==== design/vector_bank.sv ====
`timescale 1ns/100ps

module vector_bank (
	input  logic                        clk,
	input  logic                        wr_en,
	input  vec_pkg::mem_wr_t            wr,
	input  logic [vec_pkg::ADDR_W-1:0]  rd_addr,
	output vec_pkg::elem_pair_t         rd_data   // Valid one cycle after rd_addr
);
	import vec_pkg::*;

	// Bank storage, undefined until written
	logic [ELEM_W-1:0] mem_a [VEC_LEN];
	logic [ELEM_W-1:0] mem_b [VEC_LEN];

	// Single write port steered by the bank bit
	always_ff @(posedge clk) begin
		if (wr_en) begin
			if (wr.bank)
				mem_b[wr.addr] <= wr.data;
			else
				mem_a[wr.addr] <= wr.data;
		end
	end

	// Paired registered read
	// Both operands come back from one address
	always_ff @(posedge clk) begin
		rd_data.a <= mem_a[rd_addr];
		rd_data.b <= mem_b[rd_addr];
	end

	// Decoder counter must stay inside the bank
	a_wr_addr_range: assert property (@(posedge clk)
		wr_en |-> int'(wr.addr) < VEC_LEN)
		else $error("vector_bank: write address %0d out of range", wr.addr);

endmodule

// ==== design/vector_coprocessor.sv ====
`timescale 1ns/100ps

module vector_coprocessor (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        rx_valid,   // Byte strobe from the receiver
	input  logic [vec_pkg::ELEM_W-1:0]  rx_data,
	output logic                        res_valid,
	output logic [vec_pkg::RES_W-1:0]   res_data,
	output logic                        op_done
);
	import vec_pkg::*;

	// Decoder to engine
	logic cmd_valid;
	cmd_t cmd;

	// Decoder to banks
	logic    wr_en;
	mem_wr_t wr;

	// Engine to banks and back
	logic [ADDR_W-1:0] rd_addr;
	elem_pair_t        rd_data;

	command_decoder i_command_decoder (
		.clk       (clk),
		.reset     (reset),
		.rx_valid  (rx_valid),
		.rx_data   (rx_data),
		.op_done   (op_done),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.wr_en     (wr_en),
		.wr        (wr)
	);

	// Two-bank store between producer and consumer
	vector_bank i_vector_bank (
		.clk     (clk),
		.wr_en   (wr_en),
		.wr      (wr),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	vector_engine i_vector_engine (
		.clk       (clk),
		.reset     (reset),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.rd_data   (rd_data),
		.rd_addr   (rd_addr),
		.res_valid (res_valid),
		.res_data  (res_data),
		.op_done   (op_done)
	);

endmodule

// ==== design/vector_engine.sv ====
`timescale 1ns/100ps

module vector_engine (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        cmd_valid,
	input  vec_pkg::cmd_t               cmd,
	input  vec_pkg::elem_pair_t         rd_data,
	output logic [vec_pkg::ADDR_W-1:0]  rd_addr,
	output logic                        res_valid,
	output logic [vec_pkg::RES_W-1:0]   res_data,
	output logic                        op_done    // With the last res_valid
);
	import vec_pkg::*;

	typedef enum logic [1:0] {
		IDLE,   // Waiting for cmd_valid
		RUN,    // Issuing addresses
		DRAIN   // Pipeline emptying
	} state_t;

	state_t state;

	logic [ADDR_W-1:0]   addr_cnt;
	logic                rd_vld_d;   // rd_data holds a live pair
	logic                rd_last_d;  // That pair is the last element
	logic                is_reduce;  // Single-result opcodes
	logic [ELEM_W:0]     sum_ab;     // Carry kept
	logic [ELEM_W-1:0]   diff_ab;    // |a - b|
	logic [2*ELEM_W-1:0] sq_ab;
	logic [2*ELEM_W-1:0] prod_ab;
	logic [ELEM_W-1:0]   sel_elem;   // Element of the chosen bank
	logic [RES_W-1:0]    val;        // Per-element result
	logic [RES_W-1:0]    acc;

	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= IDLE;
			addr_cnt <= '0;
		end else begin
			case (state)
				IDLE: begin
					addr_cnt <= '0;
					if (cmd_valid)
						state <= RUN;
				end
				RUN: begin
					addr_cnt <= addr_cnt + 1'b1;  // Back to 0 after the last
					if (addr_cnt == LAST_ADDR)
						state <= DRAIN;
				end
				DRAIN: begin
					if (op_done)
						state <= IDLE;  // Decoder drops cmd_valid on the same edge
				end
				default: state <= IDLE;
			endcase
		end
	end

	assign rd_addr = addr_cnt;

	// Match the one-cycle bank latency
	always_ff @(posedge clk) begin
		if (reset) begin
			rd_vld_d  <= 1'b0;
			rd_last_d <= 1'b0;
		end else begin
			rd_vld_d  <= (state == RUN);
			rd_last_d <= (state == RUN) && (addr_cnt == LAST_ADDR);
		end
	end

	assign is_reduce = cmd.op inside {OP_EUC, OP_MAN, OP_DOT};

	// Arithmetic on the returned pair
	assign sum_ab   = {1'b0, rd_data.a} + {1'b0, rd_data.b};
	assign diff_ab  = (rd_data.a > rd_data.b) ? rd_data.a - rd_data.b
	                                          : rd_data.b - rd_data.a;
	assign sq_ab    = diff_ab * diff_ab;
	assign prod_ab  = rd_data.a * rd_data.b;
	assign sel_elem = cmd.bank ? rd_data.b : rd_data.a;

	always_comb begin
		case (cmd.op)
			OP_READ: val = RES_W'(sel_elem);
			OP_SUM:  val = RES_W'(sum_ab);
			OP_AVG:  val = RES_W'(sum_ab[ELEM_W:1]);  // Floor of half
			OP_EUC:  val = RES_W'(sq_ab);
			OP_MAN:  val = RES_W'(diff_ab);
			OP_DOT:  val = RES_W'(prod_ab);
			default: val = '0;
		endcase
	end

	// Reduction accumulator
	always_ff @(posedge clk) begin
		if (state == IDLE && cmd_valid)
			acc <= '0;  // Fresh start per command
		else if (rd_vld_d)
			acc <= acc + val;
	end

	// Result payload
	always_ff @(posedge clk) begin
		if (rd_vld_d)
			res_data <= is_reduce ? acc + val : val;  // Includes the last element
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			res_valid <= 1'b0;
			op_done   <= 1'b0;
		end else begin
			res_valid <= rd_vld_d && (!is_reduce || rd_last_d);  // Every stage or only the last
			op_done   <= rd_vld_d && rd_last_d;
		end
	end

	// Results only while a command is active
	a_no_res_idle: assert property (@(posedge clk) disable iff (reset)
		res_valid |-> state != IDLE)
		else $error("vector_engine: res_valid while idle");

	a_done_with_res: assert property (@(posedge clk) disable iff (reset)
		op_done |-> res_valid)
		else $error("vector_engine: op_done without res_valid");

	// One completion per command
	a_done_single: assert property (@(posedge clk) disable iff (reset)
		op_done |=> !op_done)
		else $error("vector_engine: op_done held for two cycles");

endmodule

// ==== verification/vector_coprocessor_tb.sv ====
`timescale 1ns/100ps

module vector_coprocessor_tb;
	import vec_pkg::*;

	localparam int RESET_CYCLES = 16;
	localparam int MAX_GAP      = 3;   // Idle cycles after a byte, at most
	localparam int N_CMDS       = 60;  // Commands in the run, with margin
	localparam int CYCLE_LIMIT  = N_CMDS * (VEC_LEN * (MAX_GAP + 1) + 20) + RESET_CYCLES;
	localparam int N_RANDOM     = 20;
	localparam int EXP_AW       = 10;  // Expected-result FIFO index width
	localparam int EXP_DEPTH    = 1 << EXP_AW;
	localparam int SEED         = 32'ha2f4;

	logic             clk = 1'b0;
	logic             reset;
	logic             rx_valid;
	logic [ELEM_W-1:0] rx_data;
	logic             res_valid;
	logic [RES_W-1:0] res_data;
	logic             op_done;

	// Model state
	logic [ELEM_W-1:0] shadow [2][VEC_LEN];  // Bank A at 0, bank B at 1
	logic [RES_W-1:0]  exp_mem [EXP_DEPTH];  // Expected results in arrival order
	logic [EXP_AW-1:0] wr_ptr = '0;          // Pushed by the stimulus
	logic [EXP_AW-1:0] rd_ptr = '0;          // Popped on each res_valid
	logic [EXP_AW-1:0] exp_cnt;
	logic [RES_W-1:0]  exp_head;

	int done_cnt    = 0;  // op_done pulses seen
	int done_target = 0;
	int cycle_cnt   = 0;
	int value_errs  = 0;
	int other_errs  = 0;

	assign exp_cnt  = wr_ptr - rd_ptr;
	assign exp_head = exp_mem[rd_ptr];

	always #50 clk = ~clk;  // 100 ns period

	vector_coprocessor i_vector_coprocessor (
		.clk       (clk),
		.reset     (reset),
		.rx_valid  (rx_valid),
		.rx_data   (rx_data),
		.res_valid (res_valid),
		.res_data  (res_data),
		.op_done   (op_done)
	);

	// Pop and completion bookkeeping
	always @(posedge clk) begin
		if (reset) begin
			rd_ptr   <= '0;
			done_cnt <= 0;
		end else begin
			if (res_valid && exp_cnt != '0)
				rd_ptr <= rd_ptr + 1'b1;  // Head consumed
			if (op_done)
				done_cnt <= done_cnt + 1;
		end
	end

	// Watchdog
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			other_errs++;
			$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Summary: %0d value errors, %0d other errors", value_errs, other_errs);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	// Result word against the head of the expected FIFO
	a_res_value: assert property (@(posedge clk) disable iff (reset)
		res_valid && exp_cnt != '0 |-> res_data == exp_head)
		else begin
			value_errs++;
			$display("Fail res_data: got %h, expected %h", $sampled(res_data),
				$sampled(exp_head));
		end

	a_res_expected: assert property (@(posedge clk) disable iff (reset)
		res_valid |-> exp_cnt != '0)
		else begin
			other_errs++;
			$display("Result strobe arrived while no result was expected");
		end

	// Last result of a command comes with op_done
	a_done_last: assert property (@(posedge clk) disable iff (reset)
		op_done |-> exp_cnt == EXP_AW'(1))
		else begin
			other_errs++;
			$display("op_done arrived while not exactly one result was outstanding");
		end

	function automatic logic [ELEM_W-1:0] cmd_byte(input logic bank, input op_t op);
		return {bank, 4'b0000, op};  // Bank in bit 7, opcode in bits 2 to 0
	endfunction

	// Per-element value from the shadow banks
	function automatic int elem_value(input logic bank, input op_t op, input int i);
		int a;
		int b;
		int d;
		a = int'(shadow[0][ADDR_W'(i)]);
		b = int'(shadow[1][ADDR_W'(i)]);
		d = a - b;
		case (op)
			OP_READ: return bank ? b : a;
			OP_SUM:  return a + b;
			OP_AVG:  return (a + b) / 2;  // Floor
			OP_EUC:  return d * d;
			OP_MAN:  return (d < 0) ? -d : d;
			OP_DOT:  return a * b;
			default: return 0;
		endcase
	endfunction

	task automatic push_result(input int value);
		exp_mem[wr_ptr] = RES_W'(value);
		wr_ptr = wr_ptr + 1'b1;
	endtask

	task automatic push_expected(input logic bank, input op_t op);
		int total;
		total = 0;
		for (int i = 0; i < VEC_LEN; i++) begin
			if (op inside {OP_READ, OP_SUM, OP_AVG})
				push_result(elem_value(bank, op, i));  // One word per element
			else
				total += elem_value(bank, op, i);
		end
		if (op inside {OP_EUC, OP_MAN, OP_DOT})
			push_result(total);  // Single reduced word
	endtask

	// One strobe, then a random idle gap
	task automatic send_byte(input logic [ELEM_W-1:0] b);
		int gap;
		gap = int'($urandom_range(MAX_GAP, 1));
		@(posedge clk);
		rx_valid <= 1'b1;
		rx_data  <= b;
		@(posedge clk);
		rx_valid <= 1'b0;
		repeat (gap - 1) @(posedge clk);
	endtask

	task automatic write_vector(input logic bank, input logic rand_en,
		input logic [ELEM_W-1:0] fill);
		logic [ELEM_W-1:0] v;
		send_byte(cmd_byte(bank, OP_WRITE));
		for (int i = 0; i < VEC_LEN; i++) begin
			v = rand_en ? ELEM_W'($urandom_range(255, 0)) : fill;
			shadow[bank][ADDR_W'(i)] = v;  // Model follows the data bytes
			send_byte(v);
		end
	endtask

	task automatic issue_command(input logic bank, input op_t op);
		@(negedge clk);
		done_target = done_cnt + 1;
		push_expected(bank, op);
		send_byte(cmd_byte(bank, op));
	endtask

	task automatic wait_done();
		while (done_cnt < done_target)
			@(negedge clk);  // Until the engine reports completion
	endtask

	task automatic run_command(input logic bank, input op_t op);
		issue_command(bank, op);
		wait_done();
	endtask

	initial begin
		int   missing;
		logic bank;
		op_t  op;
		void'($urandom(SEED));
		reset    = 1'b1;
		rx_valid = 1'b0;
		rx_data  = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		repeat (20) @(posedge clk);  // Quiet after reset

		// Random banks, read back each
		write_vector(1'b0, 1'b1, '0);
		write_vector(1'b1, 1'b1, '0);
		run_command(1'b0, OP_READ);
		run_command(1'b1, OP_READ);

		// Elementwise at full scale, then random
		write_vector(1'b0, 1'b0, 8'hFF);
		write_vector(1'b1, 1'b0, 8'hFF);
		run_command(1'b0, OP_SUM);
		run_command(1'b0, OP_AVG);
		write_vector(1'b0, 1'b1, '0);
		write_vector(1'b1, 1'b1, '0);
		run_command(1'b0, OP_SUM);
		run_command(1'b1, OP_AVG);

		// Reductions on random data
		run_command(1'b0, OP_EUC);
		run_command(1'b0, OP_MAN);
		run_command(1'b1, OP_DOT);

		// Largest dot product
		write_vector(1'b0, 1'b0, 8'hFF);
		write_vector(1'b1, 1'b0, 8'hFF);
		run_command(1'b0, OP_DOT);
		run_command(1'b0, OP_EUC);
		run_command(1'b0, OP_MAN);

		// Opcode 0 bytes do nothing
		write_vector(1'b0, 1'b1, '0);
		write_vector(1'b1, 1'b1, '0);
		send_byte(8'h00);
		send_byte(8'h80);
		send_byte(8'h78);  // Unused bits set
		run_command(1'b0, OP_READ);
		run_command(1'b1, OP_READ);

		// Bytes during a busy engine are dropped
		issue_command(1'b0, OP_SUM);
		send_byte(cmd_byte(1'b1, OP_WRITE));
		send_byte(cmd_byte(1'b0, OP_READ));
		wait_done();
		run_command(1'b0, OP_READ);
		run_command(1'b1, OP_READ);

		// Back-to-back random commands
		for (int n = 0; n < N_RANDOM; n++) begin
			op   = op_t'(OP_W'($urandom_range(7, 0)));
			bank = 1'($urandom_range(1, 0));
			if (op == OP_WRITE)
				write_vector(bank, 1'b1, '0);
			else if (op == OP_NONE)
				send_byte(cmd_byte(bank, OP_NONE));
			else
				run_command(bank, op);
		end

		repeat (10) @(negedge clk);
		missing = int'(exp_cnt);  // Results that never arrived
		if (missing != 0)
			$display("%0d expected results were never produced", missing);
		$display("Summary: %0d value errors, %0d other errors, %0d missing results",
			value_errs, other_errs, missing);
		if (value_errs == 0 && other_errs == 0 && missing == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule
